/* src/backend_settings.svh */
// width and size macros for the integer back end
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

`default_nettype none

// data path width
`define XLEN 32

// register file addressing
`define REG_ADDR_W 5
`define NUM_REGS 32

// free running cycle counter
`define CNT_W 64

// exception code carried with each slot
`define EXP_W 7

`default_nettype wire

`endif

/* src/backend_pkg.sv */
// opcode and source enums plus slot and writeback structs for the back end
`include "backend_settings.svh"
`default_nettype none

package backend_pkg;

    // instruction class
    typedef enum logic [0:0] {
        ITYPE_ALU = 1'b0,
        ITYPE_MUL = 1'b1
    } itype_e;

    // first operand source, CNTID reads as zero
    typedef enum logic [1:0] {
        SRC1_RF    = 2'd0,
        SRC1_PC    = 2'd1,
        SRC1_ZERO  = 2'd2,
        SRC1_CNTID = 2'd3
    } src1_sel_e;

    // second operand source
    typedef enum logic [1:0] {
        SRC2_RF   = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_CNTL = 2'd2,
        SRC2_CNTH = 2'd3
    } src2_sel_e;

    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_SRL   = 4'd6,
        OP_SLT   = 4'd7,
        OP_SLTU  = 4'd8,
        OP_MULLO = 4'd9
    } alu_op_e;

    // decoded micro-op, source selects ignored for MUL
    typedef struct packed {
        itype_e    itype;
        src1_sel_e src1;
        src2_sel_e src2;
        alu_op_e   op;
    } uop_t;

    typedef struct packed {
        logic                   en;
        uop_t                   uop;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rk;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       pc_next;
        logic [`EXP_W-1:0]      exp;
        logic [`XLEN-1:0]       imm;
    } issue_slot_t;

    // issue slot after register read
    typedef struct packed {
        issue_slot_t      slot;
        logic [`XLEN-1:0] src1_data;
        logic [`XLEN-1:0] src2_data;
    } rf_slot_t;

    // en writes the register, valid marks a retired slot
    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
        logic [`XLEN-1:0]       pc;
        logic [`EXP_W-1:0]      exp;
        logic                   valid;
    } wb_port_t;

endpackage

`default_nettype wire

/* src/alu_unit.sv */
// one execution pipe with add, sub, logic, shifts, compares and low multiply
`include "backend_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import backend_pkg::*;
(
    input  alu_op_e          op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] result
);

    logic [4:0]       shamt;
    logic [`XLEN-1:0] product;
    logic             lt_signed;
    logic             lt_unsigned;

    assign shamt       = b[4:0];
    // low half of the product
    assign product     = a * b;
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            OP_ADD: begin
                result = a + b;
            end
            OP_SUB: begin
                result = a - b;
            end
            OP_AND: begin
                result = a & b;
            end
            OP_OR: begin
                result = a | b;
            end
            OP_XOR: begin
                result = a ^ b;
            end
            OP_SLL: begin
                result = a << shamt;
            end
            OP_SRL: begin
                result = a >> shamt;
            end
            OP_SLT: begin
                result = {{(`XLEN-1){1'b0}}, lt_signed};
            end
            OP_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            end
            OP_MULLO: begin
                result = product;
            end
            // unused encodings
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/register_read_stage.sv */
// register file, stable counter, operand select with bypass and the read pipeline register
`include "backend_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module register_read_stage
    import backend_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        stall,
    input  logic        flush,
    input  issue_slot_t issue_0,
    input  issue_slot_t issue_1,
    input  wb_port_t    wb_0,
    input  wb_port_t    wb_1,
    output rf_slot_t    rf_0,
    output rf_slot_t    rf_1
);

    logic [`XLEN-1:0]  regs [0:`NUM_REGS-1];
    logic [`CNT_W-1:0] stable_cnt;

    issue_slot_t issue [2];
    rf_slot_t    rf_q  [2];

    assign issue[0] = issue_0;
    assign issue[1] = issue_1;

    assign rf_0 = rf_q[0];
    assign rf_1 = rf_q[1];

    // two write ports
    always_ff @(posedge clk) begin
        if (wb_0.en) begin
            regs[wb_0.addr] <= wb_0.data;
        end
        // port 1 lands last and wins on a shared address
        if (wb_1.en) begin
            regs[wb_1.addr] <= wb_1.data;
        end
    end

    // runs through stalls
    always_ff @(posedge clk) begin
        if (!rstn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // r0, then wb_1, then wb_0, then the array
    function automatic logic [`XLEN-1:0] reg_value(input logic [`REG_ADDR_W-1:0] addr);
        logic [`XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_1.en && wb_1.addr == addr) begin
            value = wb_1.data;
        end else if (wb_0.en && wb_0.addr == addr) begin
            value = wb_0.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    function automatic logic [`XLEN-1:0] src1_value(input issue_slot_t s);
        logic [`XLEN-1:0] value;
        value = reg_value(s.rj);
        // MUL always takes the register
        if (s.uop.itype == ITYPE_ALU) begin
            case (s.uop.src1)
                SRC1_RF: begin
                    value = reg_value(s.rj);
                end
                SRC1_PC: begin
                    value = s.pc;
                end
                SRC1_ZERO, SRC1_CNTID: begin
                    value = '0;
                end
                default: begin
                    value = '0;
                end
            endcase
        end
        return value;
    endfunction

    function automatic logic [`XLEN-1:0] src2_value(input issue_slot_t s);
        logic [`XLEN-1:0] value;
        value = reg_value(s.rk);
        if (s.uop.itype == ITYPE_ALU) begin
            case (s.uop.src2)
                SRC2_RF: begin
                    value = reg_value(s.rk);
                end
                SRC2_IMM: begin
                    value = s.imm;
                end
                SRC2_CNTL: begin
                    value = stable_cnt[`XLEN-1:0];
                end
                SRC2_CNTH: begin
                    value = stable_cnt[`CNT_W-1:`XLEN];
                end
                default: begin
                    value = '0;
                end
            endcase
        end
        return value;
    endfunction

    for (genvar i = 0; i < 2; i++) begin : g_slot
        // flush beats stall, payload follows en
        always_ff @(posedge clk) begin
            if (!rstn || flush) begin
                rf_q[i].slot.en <= 1'b0;
            end else if (!stall) begin
                rf_q[i].slot      <= issue[i];
                rf_q[i].src1_data <= src1_value(issue[i]);
                rf_q[i].src2_data <= src2_value(issue[i]);
            end
        end
    end

    // nothing leaves the read stage the cycle after a flush or reset
    a_rf_cleared: assert property (
        @(posedge clk) (!rstn || flush) |=> (!rf_0.slot.en && !rf_1.slot.en)
    ) else $error("rf slot enabled one cycle after flush or reset");

endmodule

`default_nettype wire

/* src/execute_stage.sv */
// two ALU pipes and the registered writeback ports
`include "backend_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import backend_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     stall,
    input  logic     flush,
    input  rf_slot_t rf_0,
    input  rf_slot_t rf_1,
    output wb_port_t wb_0,
    output wb_port_t wb_1
);

    rf_slot_t rf_in [2];
    wb_port_t wb_q  [2];

    assign rf_in[0] = rf_0;
    assign rf_in[1] = rf_1;

    assign wb_0 = wb_q[0];
    assign wb_1 = wb_q[1];

    for (genvar i = 0; i < 2; i++) begin : g_pipe
        alu_op_e          op;
        logic [`XLEN-1:0] result;
        logic             writes;

        // MUL ignores its op field
        assign op = (rf_in[i].slot.uop.itype == ITYPE_MUL) ? OP_MULLO : rf_in[i].slot.uop.op;

        // no write for r0 or a raised exception
        assign writes = rf_in[i].slot.en
                        && (rf_in[i].slot.exp == '0)
                        && (rf_in[i].slot.rd != '0);

        alu_unit i_alu (
            .op     (op),
            .a      (rf_in[i].src1_data),
            .b      (rf_in[i].src2_data),
            .result (result)
        );

        // stall and flush both leave a bubble
        always_ff @(posedge clk) begin
            if (!rstn || flush || stall) begin
                wb_q[i].en    <= 1'b0;
                wb_q[i].valid <= 1'b0;
            end else begin
                wb_q[i].en    <= writes;
                wb_q[i].valid <= rf_in[i].slot.en;
                wb_q[i].addr  <= rf_in[i].slot.rd;
                wb_q[i].data  <= result;
                wb_q[i].pc    <= rf_in[i].slot.pc;
                wb_q[i].exp   <= rf_in[i].slot.exp;
            end
        end

        // r0 is never written back
        a_wb_addr_nonzero: assert property (
            @(posedge clk) disable iff (!rstn) wb_q[i].en |-> (wb_q[i].addr != '0)
        ) else $error("wb port %0d enabled with address zero", i);
    end

endmodule

`default_nettype wire

/* src/backend_core.sv */
// top level joining the register read stage and the execute stage
`include "backend_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module backend_core
    import backend_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        stall,
    input  logic        flush,
    input  issue_slot_t issue_0,
    input  issue_slot_t issue_1,
    output wb_port_t    wb_0,
    output wb_port_t    wb_1
);

    rf_slot_t rf_0;
    rf_slot_t rf_1;

    register_read_stage i_register_read_stage (
        .clk     (clk),
        .rstn    (rstn),
        .stall   (stall),
        .flush   (flush),
        .issue_0 (issue_0),
        .issue_1 (issue_1),
        // writebacks loop back as the write ports
        .wb_0    (wb_0),
        .wb_1    (wb_1),
        .rf_0    (rf_0),
        .rf_1    (rf_1)
    );

    execute_stage i_execute_stage (
        .clk   (clk),
        .rstn  (rstn),
        .stall (stall),
        .flush (flush),
        .rf_0  (rf_0),
        .rf_1  (rf_1),
        .wb_0  (wb_0),
        .wb_1  (wb_1)
    );

endmodule

`default_nettype wire

/* verification/backend_tb_vectors.svh */
// row types, slot and writeback builders and the stimulus table for the back end testbench
`ifndef BACKEND_TB_VECTORS_SVH
`define BACKEND_TB_VECTORS_SVH

localparam int NUM_ROWS = 30;

// pc of every slot unless a row sets its own
localparam logic [`XLEN-1:0] SLOT_PC = 32'h1000;

// cnt_rel adds the cycle count of the issuing row to data
typedef struct packed {
    logic                   en;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`XLEN-1:0]       data;
    logic                   valid;
    logic                   cnt_rel;
    logic [`XLEN-1:0]       pc;
    logic [`EXP_W-1:0]      exp;
} wb_exp_t;

string       row_name  [NUM_ROWS];
issue_slot_t row_s0    [NUM_ROWS];
issue_slot_t row_s1    [NUM_ROWS];
logic        row_stall [NUM_ROWS];
logic        row_flush [NUM_ROWS];
wb_exp_t     row_e0    [NUM_ROWS];
wb_exp_t     row_e1    [NUM_ROWS];
int          row_count = 0;

function automatic issue_slot_t make_slot(itype_e t, src1_sel_e s1, src2_sel_e s2,
                                          alu_op_e op, int rd, int rj, int rk,
                                          logic [`XLEN-1:0] imm);
    issue_slot_t s;
    s.en        = 1'b1;
    s.uop.itype = t;
    s.uop.src1  = s1;
    s.uop.src2  = s2;
    s.uop.op    = op;
    s.rd        = rd[`REG_ADDR_W-1:0];
    s.rj        = rj[`REG_ADDR_W-1:0];
    s.rk        = rk[`REG_ADDR_W-1:0];
    s.pc        = SLOT_PC;
    s.pc_next   = $urandom;
    s.exp       = '0;
    s.imm       = imm;
    return s;
endfunction

// unused fields get random filler
function automatic issue_slot_t rr(alu_op_e op, int rd, int rj, int rk);
    return make_slot(ITYPE_ALU, SRC1_RF, SRC2_RF, op, rd, rj, rk, $urandom);
endfunction

function automatic issue_slot_t ri(alu_op_e op, int rd, int rj, logic [`XLEN-1:0] imm);
    return make_slot(ITYPE_ALU, SRC1_RF, SRC2_IMM, op, rd, rj, $urandom, imm);
endfunction

function automatic issue_slot_t mul(int rd, int rj, int rk);
    return make_slot(ITYPE_MUL, src1_sel_e'($urandom_range(3, 0)),
                     src2_sel_e'($urandom_range(3, 0)), alu_op_e'($urandom_range(8, 0)),
                     rd, rj, rk, $urandom);
endfunction

function automatic issue_slot_t sel(src1_sel_e s1, src2_sel_e s2, int rd,
                                    logic [`XLEN-1:0] pc, logic [`XLEN-1:0] imm);
    issue_slot_t s;
    s    = make_slot(ITYPE_ALU, s1, s2, OP_ADD, rd, $urandom, $urandom, imm);
    s.pc = pc;
    return s;
endfunction

function automatic issue_slot_t nop();
    return '0;
endfunction

function automatic issue_slot_t with_exp(issue_slot_t s, int code);
    s.exp = code[`EXP_W-1:0];
    return s;
endfunction

function automatic wb_exp_t wr(int addr, logic [`XLEN-1:0] data);
    return {1'b1, addr[`REG_ADDR_W-1:0], data, 1'b1, 1'b0, SLOT_PC, {`EXP_W{1'b0}}};
endfunction

function automatic wb_exp_t cn(int addr, logic [`XLEN-1:0] offset);
    return {1'b1, addr[`REG_ADDR_W-1:0], offset, 1'b1, 1'b1, SLOT_PC, {`EXP_W{1'b0}}};
endfunction

// retired without a write
function automatic wb_exp_t rv();
    return {1'b0, 5'd0, 32'd0, 1'b1, 1'b0, SLOT_PC, {`EXP_W{1'b0}}};
endfunction

function automatic wb_exp_t bub();
    return '0;
endfunction

function automatic wb_exp_t retired_pc(wb_exp_t e, logic [`XLEN-1:0] pc);
    e.pc = pc;
    return e;
endfunction

function automatic wb_exp_t retired_exp(wb_exp_t e, int code);
    e.exp = code[`EXP_W-1:0];
    return e;
endfunction

task automatic add_row(string name, issue_slot_t s0, issue_slot_t s1, logic st, logic fl,
                       wb_exp_t e0, wb_exp_t e1);
    row_name[row_count]  = name;
    row_s0[row_count]    = s0;
    row_s1[row_count]    = s1;
    row_stall[row_count] = st;
    row_flush[row_count] = fl;
    row_e0[row_count]    = e0;
    row_e1[row_count]    = e1;
    row_count++;
endtask

// a consumer issues two or more rows after its producer
task automatic load_rows();
    add_row("imm_load_a", ri(OP_ADD, 1, 0, 32'h5), ri(OP_ADD, 2, 0, 32'hffff_fff0), 0, 0,
            wr(1, 32'h5), wr(2, 32'hffff_fff0));
    add_row("imm_load_b", ri(OP_ADD, 3, 0, 32'h7), ri(OP_ADD, 4, 0, 32'h8000_0000), 0, 0,
            wr(3, 32'h7), wr(4, 32'h8000_0000));
    add_row("add_sub_bypass", rr(OP_ADD, 5, 1, 2), rr(OP_SUB, 6, 2, 1), 0, 0,
            wr(5, 32'hffff_fff5), wr(6, 32'hffff_ffeb));
    add_row("and_or_mixed", rr(OP_AND, 7, 3, 1), rr(OP_OR, 8, 3, 4), 0, 0,
            wr(7, 32'h5), wr(8, 32'h8000_0007));
    add_row("xor_sll", rr(OP_XOR, 9, 5, 6), ri(OP_SLL, 10, 1, 32'h4), 0, 0,
            wr(9, 32'h1e), wr(10, 32'h50));
    add_row("srl_slt", rr(OP_SRL, 11, 4, 1), rr(OP_SLT, 12, 2, 1), 0, 0,
            wr(11, 32'h0400_0000), wr(12, 32'h1));
    add_row("sltu_mul", rr(OP_SLTU, 13, 2, 1), mul(14, 3, 2), 0, 0,
            wr(13, 32'h0), wr(14, 32'hffff_ff90));
    add_row("mul_add_file", mul(15, 1, 3), rr(OP_ADD, 16, 9, 10), 0, 0,
            wr(15, 32'h23), wr(16, 32'h6e));
    add_row("pipe0_producer", ri(OP_ADD, 17, 0, 32'h11), nop(), 0, 0, wr(17, 32'h11), bub());
    add_row("pipe1_reads_pipe0", nop(), ri(OP_ADD, 18, 15, 32'h1), 0, 0, bub(), wr(18, 32'h24));
    add_row("same_rd_both", ri(OP_ADD, 20, 0, 32'haa), ri(OP_ADD, 20, 0, 32'hbb), 0, 0,
            wr(20, 32'haa), wr(20, 32'hbb));
    add_row("gap_a", nop(), nop(), 0, 0, bub(), bub());
    add_row("same_rd_bypass", ri(OP_ADD, 21, 20, 32'h0), nop(), 0, 0, wr(21, 32'hbb), bub());
    add_row("gap_b", nop(), nop(), 0, 0, bub(), bub());
    add_row("same_rd_file_r0", ri(OP_ADD, 22, 20, 32'h1), rr(OP_ADD, 23, 0, 1), 0, 0,
            wr(22, 32'hbc), wr(23, 32'h5));
    add_row("no_write", ri(OP_ADD, 0, 1, 32'h9), with_exp(ri(OP_ADD, 1, 0, 32'h99), 3), 0, 0,
            rv(), retired_exp(rv(), 3));
    add_row("gap_c", nop(), nop(), 0, 0, bub(), bub());
    add_row("old_value", ri(OP_ADD, 24, 1, 32'h0), ri(OP_ADD, 25, 0, 32'h0), 0, 0,
            wr(24, 32'h5), wr(25, 32'h0));
    add_row("src_pc_zero", sel(SRC1_PC, SRC2_IMM, 26, 32'h2000, 32'h10),
            sel(SRC1_ZERO, SRC2_IMM, 27, 32'h1000, 32'h33), 0, 0,
            retired_pc(wr(26, 32'h2010), 32'h2000), wr(27, 32'h33));
    add_row("src_cntid_cntl", sel(SRC1_CNTID, SRC2_IMM, 28, 32'h1000, 32'h44),
            sel(SRC1_ZERO, SRC2_CNTL, 29, 32'h1000, 32'h0), 0, 0,
            wr(28, 32'h44), cn(29, 32'h0));
    add_row("src_pc_cnt", sel(SRC1_PC, SRC2_CNTL, 30, 32'h3000, 32'h0),
            sel(SRC1_ZERO, SRC2_CNTH, 31, 32'h1000, 32'h0), 0, 0,
            retired_pc(cn(30, 32'h3000), 32'h3000), wr(31, 32'h0));
    add_row("pre_stall", ri(OP_ADD, 2, 0, 32'h123), ri(OP_ADD, 3, 0, 32'h456), 0, 0,
            bub(), bub());
    add_row("stall_a", nop(), nop(), 1, 0, bub(), bub());
    add_row("stall_b", nop(), nop(), 1, 0, wr(2, 32'h123), wr(3, 32'h456));
    add_row("after_stall", nop(), nop(), 0, 0, bub(), bub());
    add_row("held_bypass", ri(OP_ADD, 4, 2, 32'h1), rr(OP_ADD, 5, 3, 2), 0, 0,
            wr(4, 32'h124), wr(5, 32'h579));
    add_row("pre_flush", ri(OP_ADD, 6, 0, 32'h77), ri(OP_ADD, 7, 0, 32'h88), 0, 0,
            bub(), bub());
    add_row("flush", ri(OP_ADD, 6, 0, 32'h66), nop(), 0, 1, bub(), bub());
    add_row("after_flush", ri(OP_ADD, 8, 6, 32'h0), ri(OP_ADD, 9, 7, 32'h0), 0, 0,
            wr(8, 32'hffff_ffeb), wr(9, 32'h5));
    add_row("after_flush_mul", ri(OP_ADD, 10, 0, 32'h3c), mul(11, 5, 3), 0, 0,
            wr(10, 32'h3c), wr(11, 32'h0017_baa6));
endtask

`endif

/* verification/backend_core_tb.sv */
// testbench for the back end with clock, reset, table loop, checks and watchdog
`include "backend_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module backend_core_tb
    import backend_pkg::*;
;

    logic        clk;
    logic        rstn;
    logic        stall;
    logic        flush;
    issue_slot_t issue_0;
    issue_slot_t issue_1;
    wb_port_t    wb_0;
    wb_port_t    wb_1;

    int     errors = 0;
    int     checks = 0;
    longint cycles = 0;

    `include "backend_tb_vectors.svh"

    // counter value each row reads
    longint row_cycles [NUM_ROWS];

    backend_core i_backend_core (
        .clk     (clk),
        .rstn    (rstn),
        .stall   (stall),
        .flush   (flush),
        .issue_0 (issue_0),
        .issue_1 (issue_1),
        .wb_0    (wb_0),
        .wb_1    (wb_1)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    // edges with reset released, same as the stable counter
    always @(posedge clk) begin
        if (rstn) begin
            cycles <= cycles + 1;
        end
    end

    task automatic compare_port(input string name, input int port, input wb_exp_t e,
                                input wb_port_t a, input longint cnt);
        logic [`XLEN-1:0] data;
        data = e.cnt_rel ? e.data + cnt[`XLEN-1:0] : e.data;
        checks++;
        if (a.valid !== e.valid) begin
            errors++;
            $display("mismatch %s wb_%0d valid: expected %0b actual %0b",
                     name, port, e.valid, a.valid);
        end
        if (a.en !== e.en) begin
            errors++;
            $display("mismatch %s wb_%0d en: expected %0b actual %0b", name, port, e.en, a.en);
        end
        if (e.en && a.addr !== e.addr) begin
            errors++;
            $display("mismatch %s wb_%0d addr: expected %0d actual %0d",
                     name, port, e.addr, a.addr);
        end
        if (e.en && a.data !== data) begin
            errors++;
            $display("mismatch %s wb_%0d data: expected %h actual %h", name, port, data, a.data);
        end
        if (e.valid && a.pc !== e.pc) begin
            errors++;
            $display("mismatch %s wb_%0d pc: expected %h actual %h", name, port, e.pc, a.pc);
        end
        if (e.valid && a.exp !== e.exp) begin
            errors++;
            $display("mismatch %s wb_%0d exp: expected %0d actual %0d",
                     name, port, e.exp, a.exp);
        end
    endtask

    initial begin
        #((NUM_ROWS + 20) * 8);
        $display("timeout: the table did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int i;
        void'($urandom(18));
        rstn    = 1'b0;
        stall   = 1'b0;
        flush   = 1'b0;
        issue_0 = '0;
        issue_1 = '0;
        load_rows();
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        // a row's writeback shows two rows after it is driven
        for (i = 0; i < NUM_ROWS + 2; i++) begin
            if (i >= 2) begin
                compare_port(row_name[i-2], 0, row_e0[i-2], wb_0, row_cycles[i-2]);
                compare_port(row_name[i-2], 1, row_e1[i-2], wb_1, row_cycles[i-2]);
            end else if (wb_0.valid !== 1'b0 || wb_1.valid !== 1'b0) begin
                errors++;
                $display("a writeback valid bit was high right after reset");
            end
            if (i < NUM_ROWS) begin
                issue_0       = row_s0[i];
                issue_1       = row_s1[i];
                stall         = row_stall[i];
                flush         = row_flush[i];
                row_cycles[i] = cycles;
            end else begin
                issue_0 = '0;
                issue_1 = '0;
                stall   = 1'b0;
                flush   = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* backend_core.f */
+incdir+src
+incdir+verification
src/backend_pkg.sv
src/alu_unit.sv
src/register_read_stage.sv
src/execute_stage.sv
src/backend_core.sv
verification/backend_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the back end testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module backend_core_tb \
    -f backend_core.f -Mdir obj_dir -o backend_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/backend_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "test failed, see sim.log"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "no result in sim.log"
    exit 1
fi

echo "test passed"
exit 0
